//--- build.f
+incdir+.
flush_pkg.sv
commit_event_decoder.sv
flush_controller.sv
redirect_unit.sv
flush_ctrl_top.sv
flush_ctrl_assert.sv
tb_flush_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the flush control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_flush_ctrl --Mdir obj_dir -o sim_flush_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
./obj_dir/sim_flush_ctrl +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -qx "all tests passed" sim.log; then
    exit 1
fi
exit 0

//--- tb_flush_ctrl.sv
// --------------------
// Flush control testbench
// Directed and LFSR-driven commit and branch events with a cache ack model
// --------------------

`timescale 1ns/1ps

`include "flush_settings.svh"

module tb_flush_ctrl;

    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED  = 32'hfbe1;
    localparam int          WAIT_LIMIT = 40;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       halt_csr_i;
    logic                       dcache_flush_ack_i;
    logic                       dcache_flush_o;
    logic                       halt_o;
    flush_pkg::commit_event_t   commit_i;
    flush_pkg::branch_resolve_t branch_i;
    flush_pkg::flush_vec_t      flush_o;
    flush_pkg::redirect_t       redirect_o;
    logic [31:0]                stim_lfsr;
    logic [31:0]                ack_lfsr;
    int                         timeouts;
    int                         mismatches;

    flush_ctrl_top dut (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .commit_i           (commit_i),
        .branch_i           (branch_i),
        .halt_csr_i         (halt_csr_i),
        .dcache_flush_ack_i (dcache_flush_ack_i),
        .flush_o            (flush_o),
        .dcache_flush_o     (dcache_flush_o),
        .halt_o             (halt_o),
        .redirect_o         (redirect_o)
    );

    // 20 ns clock
    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, inout logic [31:0] s, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
    endtask

    // Expected fetch target, highest priority first
    function automatic flush_pkg::redirect_t predict_redirect(
        input flush_pkg::commit_event_t c, input flush_pkg::branch_resolve_t b);
        flush_pkg::redirect_t r;
        logic                 seq_pc;
        r      = '0;
        seq_pc = c.valid && (c.op inside {flush_pkg::OP_FENCE, flush_pkg::OP_FENCE_I,
                 flush_pkg::OP_SFENCE_VMA, flush_pkg::OP_CSR_FLUSH});
        // Hypervisor fences only count with the extension
        if (c.valid && (`FLUSH_HYP_EN == 1)
            && (c.op inside {flush_pkg::OP_HFENCE_VVMA, flush_pkg::OP_HFENCE_GVMA})) begin
            seq_pc = 1'b1;
        end
        r.valid = 1'b1;
        if (c.valid && c.op == flush_pkg::OP_EXCEPTION) begin
            r.pc = `FLUSH_TRAP_VECTOR;
        end else if (c.valid && c.op == flush_pkg::OP_ERET) begin
            r.pc = c.target;
        end else if (seq_pc) begin
            r.pc = c.pc + `FLUSH_XLEN'd4;
        end else if (b.valid && b.mispredict) begin
            r.pc = b.target;
        end else begin
            r = '0;
        end
        return r;
    endfunction

    // One-cycle strobe, then the redirect check
    task automatic send_event(input flush_pkg::commit_event_t c,
                              input flush_pkg::branch_resolve_t b);
        flush_pkg::redirect_t exp;
        int                   cycles;
        exp    = predict_redirect(c, b);
        cycles = 0;
        // No back-pressure, so hold off while halted
        while (halt_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (halt_o) begin
            timeouts++;
            $display("Timeout at %0t: halt never dropped after the cache fence", $time);
        end
        @(posedge clk_i);
        #1;
        commit_i = c;
        branch_i = b;
        @(posedge clk_i);
        #1;
        commit_i = '0;
        branch_i = '0;
        if (exp.valid) begin
            cycles = 0;
            while (!redirect_o.valid && cycles < WAIT_LIMIT) begin
                @(negedge clk_i);
                cycles++;
            end
            if (!redirect_o.valid) begin
                timeouts++;
                $display("Timeout at %0t: no redirect after a flushing event", $time);
            end else if (redirect_o.pc !== exp.pc) begin
                mismatches++;
                $display("Fail %0t: redirect pc %h, expected %h", $time, redirect_o.pc, exp.pc);
            end else if (cycles != 2) begin
                mismatches++;
                $display("Fail %0t: redirect came %0d cycles after the strobe, expected 2",
                         $time, cycles);
            end
        end else begin
            // No redirect expected for a quiet event
            repeat (2) @(negedge clk_i);
        end
    endtask

    task automatic directed_event(input flush_pkg::commit_op_e op, input logic virt,
                                  input logic [31:0] pc, input logic [31:0] target,
                                  input logic misp, input logic [31:0] btarget);
        flush_pkg::commit_event_t   c;
        flush_pkg::branch_resolve_t b;
        c = '{valid: (op != flush_pkg::OP_NONE), op: op, virt: virt, pc: pc, target: target};
        b = '{valid: misp, mispredict: misp, target: btarget};
        send_event(c, b);
    endtask

    task automatic random_event();
        flush_pkg::commit_event_t   c;
        flush_pkg::branch_resolve_t b;
        logic [31:0]                v;
        draw_bits(1, stim_lfsr, v);
        c.valid = v[0];
        // Codes past OP_ERET fold to no-op
        draw_bits(4, stim_lfsr, v);
        c.op = (v[3:0] > 4'd8) ? flush_pkg::OP_NONE : flush_pkg::commit_op_e'(v[3:0]);
        draw_bits(1, stim_lfsr, v);
        c.virt = v[0];
        draw_bits(32, stim_lfsr, v);
        c.pc = {v[31:2], 2'b00};
        draw_bits(32, stim_lfsr, v);
        c.target = v;
        draw_bits(2, stim_lfsr, v);
        b.valid      = v[1];
        b.mispredict = v[0];
        draw_bits(32, stim_lfsr, v);
        b.target = v;
        send_event(c, b);
    endtask

    // --------------------
    // Data cache ack model
    // --------------------
    initial begin : ack_model
        logic [31:0] delay;
        dcache_flush_ack_i = 1'b0;
        ack_lfsr           = LFSR_SEED;
        forever begin
            @(posedge clk_i);
            #1;
            dcache_flush_ack_i = 1'b0;
            if (dcache_flush_o) begin
                // Writeback takes 0 to 7 extra cycles
                draw_bits(3, ack_lfsr, delay);
                repeat (delay) @(posedge clk_i);
                #1;
                dcache_flush_ack_i = 1'b1;
            end
        end
    end

    initial begin : main
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        halt_csr_i = 1'b0;
        commit_i   = '0;
        branch_i   = '0;
        stim_lfsr  = LFSR_SEED;
        timeouts   = 0;
        mismatches = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Directed cases, one per flush rule
        directed_event(flush_pkg::OP_NONE, 1'b0, 32'h0, 32'h0, 1'b1, 32'h0000_1200);
        directed_event(flush_pkg::OP_FENCE_I, 1'b0, 32'h0000_2000, 32'h0, 1'b0, 32'h0);
        directed_event(flush_pkg::OP_SFENCE_VMA, 1'b1, 32'h0000_2100, 32'h0, 1'b0, 32'h0);
        directed_event(flush_pkg::OP_HFENCE_GVMA, 1'b0, 32'h0000_2200, 32'h0, 1'b0, 32'h0);
        directed_event(flush_pkg::OP_EXCEPTION, 1'b0, 32'h0000_2300, 32'h5555_0000, 1'b0, 32'h0);
        directed_event(flush_pkg::OP_ERET, 1'b0, 32'h0000_2400, 32'h0000_3000, 1'b0, 32'h0);
        // Commit event wins over a same-cycle mispredict
        directed_event(flush_pkg::OP_CSR_FLUSH, 1'b0, 32'h0000_2500, 32'h0, 1'b1, 32'h0000_7000);
        directed_event(flush_pkg::OP_FENCE, 1'b0, 32'h0000_2600, 32'h0, 1'b0, 32'h0);

        repeat (200) random_event();
        repeat (3) @(negedge clk_i);

        $display("timeouts %0d, redirect mismatches %0d, assertion failures %0d",
                 timeouts, mismatches, dut.u_assert.fail_count);
        if (timeouts + mismatches + dut.u_assert.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flush_ctrl_assert.sv
// --------------------
// Flush control checks
// Concurrent checks on the top-level flush, fence and redirect ports
// --------------------

`timescale 1ns/1ps

`include "flush_settings.svh"

module flush_ctrl_assert (
    input logic                       clk_i,
    input logic                       rst_ni,
    input flush_pkg::commit_event_t   commit_i,
    input flush_pkg::branch_resolve_t branch_i,
    input logic                       halt_csr_i,
    input logic                       dcache_flush_ack_i,
    input flush_pkg::flush_vec_t      flush_o,
    input logic                       dcache_flush_o,
    input logic                       halt_o,
    input flush_pkg::redirect_t       redirect_o
);

    // Front-end only flush of a lone mispredict
    localparam flush_pkg::flush_vec_t FRONT_VEC = '{flush_if: 1'b1, flush_unissued: 1'b1,
                                                   default: 1'b0};

    int                    fail_count;
    logic                  misp;
    logic                  commit_any;
    logic                  quiet;
    // Commit fence that writes back the data cache
    logic                  fence_any;

    initial fail_count = 0;

    assign misp       = branch_i.valid && branch_i.mispredict;
    assign commit_any = commit_i.valid && (commit_i.op != flush_pkg::OP_NONE);
    assign quiet      = !misp && !commit_any;
    assign fence_any  = commit_any && (commit_i.op == flush_pkg::OP_FENCE
                                       || commit_i.op == flush_pkg::OP_FENCE_I);

    task automatic note_failure(input string msg);
        fail_count++;
        $error("%s", msg);
    endtask

    // --------------------
    // Flush vector, one cycle after the strobe
    // --------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        misp && !commit_any |=> flush_o == FRONT_VEC)
        else note_failure("lone mispredict gave the wrong flush vector");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_any && commit_i.op == flush_pkg::OP_FENCE_I
        |=> flush_o.set_pc_commit && flush_o.flush_if && flush_o.flush_unissued
            && flush_o.flush_id && flush_o.flush_ex && flush_o.flush_icache
            && flush_o.flush_dcache == (`FLUSH_WB_DCACHE == 1))
        else note_failure("fence.i did not flush the pipeline and caches");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_any && commit_i.op == flush_pkg::OP_SFENCE_VMA && commit_i.virt
        && (`FLUSH_HYP_EN == 1)
        |=> flush_o.flush_tlb_vvma && !flush_o.flush_tlb)
        else note_failure("virtualized sfence hit the wrong TLB");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_any && commit_i.op == flush_pkg::OP_HFENCE_GVMA && (`FLUSH_HYP_EN == 1)
        |=> flush_o.flush_tlb_gvma && !flush_o.flush_tlb && !flush_o.flush_tlb_vvma)
        else note_failure("hfence.gvma raised the wrong TLB flush");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_any && commit_i.op == flush_pkg::OP_EXCEPTION
        |=> !flush_o.set_pc_commit && flush_o.flush_bp)
        else note_failure("exception kept set_pc_commit or missed flush_bp");
    assert property (@(posedge clk_i) disable iff (!rst_ni) quiet |=> flush_o == '0)
        else note_failure("flush raised without a strobe");

    // --------------------
    // Fence handshake and redirect
    // --------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fence_any && (`FLUSH_WB_DCACHE == 1) |-> ##2 dcache_flush_o && halt_o)
        else note_failure("fence did not start the cache flush");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(dcache_flush_o) |-> $past(fence_any, 2))
        else note_failure("cache flush started without a fence");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_flush_o && !dcache_flush_ack_i |=> dcache_flush_o)
        else note_failure("cache flush dropped before the ack");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_flush_o && dcache_flush_ack_i |=> !dcache_flush_o && (!halt_o || halt_csr_i))
        else note_failure("cache flush or halt still high after the ack");
    assert property (@(posedge clk_i) disable iff (!rst_ni) !halt_csr_i |-> halt_o == dcache_flush_o)
        else note_failure("halt out of step with the cache flush");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_any && commit_i.op == flush_pkg::OP_EXCEPTION
        |-> ##2 redirect_o.valid && redirect_o.pc == `FLUSH_TRAP_VECTOR)
        else note_failure("exception did not redirect to the trap vector");
    assert property (@(posedge clk_i) disable iff (!rst_ni) quiet |-> ##2 !redirect_o.valid)
        else note_failure("redirect raised without a strobe");

endmodule

bind flush_ctrl_top flush_ctrl_assert u_assert (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .commit_i           (commit_i),
    .branch_i           (branch_i),
    .halt_csr_i         (halt_csr_i),
    .dcache_flush_ack_i (dcache_flush_ack_i),
    .flush_o            (flush_o),
    .dcache_flush_o     (dcache_flush_o),
    .halt_o             (halt_o),
    .redirect_o         (redirect_o)
);

//--- flush_ctrl_top.sv
// --------------------
// Flush and redirect top
// Decode, flush control and fetch redirect for the core
// --------------------

`timescale 1ns/1ps

module flush_ctrl_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  flush_pkg::commit_event_t   commit_i,
    input  flush_pkg::branch_resolve_t branch_i,
    input  logic                       halt_csr_i,
    input  logic                       dcache_flush_ack_i,
    output flush_pkg::flush_vec_t      flush_o,
    output logic                       dcache_flush_o,
    output logic                       halt_o,
    output flush_pkg::redirect_t       redirect_o
);

    // Registered request shared by both consumers
    flush_pkg::flush_req_t req;

    // --------------------
    // Decode stage
    // --------------------
    commit_event_decoder u_decoder (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .commit_i (commit_i),
        .branch_i (branch_i),
        .req_o    (req)
    );

    // Flush vector and cache fence
    flush_controller u_controller (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .req_i              (req),
        .halt_csr_i         (halt_csr_i),
        .dcache_flush_ack_i (dcache_flush_ack_i),
        .flush_o            (flush_o),
        .dcache_flush_o     (dcache_flush_o),
        .halt_o             (halt_o)
    );

    // Next fetch PC, one cycle behind the flush
    redirect_unit u_redirect (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_i      (req),
        .redirect_o (redirect_o)
    );

endmodule

//--- redirect_unit.sv
// --------------------
// Redirect unit
// Picks the next fetch PC by priority and registers it
// --------------------

`timescale 1ns/1ps

module redirect_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  flush_pkg::flush_req_t req_i,
    output flush_pkg::redirect_t  redirect_o
);

    flush_pkg::redirect_t redirect_d;
    logic                 valid_q;
    logic [$bits(redirect_d.pc)-1:0] pc_q;
    // Events that resume fetch at commit pc+4
    logic                 set_pc_commit;

    assign set_pc_commit = req_i.fence | req_i.fence_i | req_i.sfence | req_i.hfence_vvma
                         | req_i.hfence_gvma | req_i.csr_flush;

    // --------------------
    // Target priority
    // --------------------
    always_comb begin : target_select
        redirect_d = '0;
        if (req_i.exception || req_i.eret) begin
            // Trap vector or epc, formed in decode
            redirect_d.valid = 1'b1;
            redirect_d.pc    = req_i.trap_target;
        end else if (set_pc_commit) begin
            redirect_d.valid = 1'b1;
            redirect_d.pc    = req_i.commit_pc;
        end else if (req_i.mispredict) begin
            // Lowest priority since a younger branch loses to any commit event
            redirect_d.valid = 1'b1;
            redirect_d.pc    = req_i.branch_target;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= redirect_d.valid;
        end
    end

    // Registered fetch target
    always_ff @(posedge clk_i) begin
        pc_q <= redirect_d.pc;
    end

    always_comb begin
        redirect_o.valid = valid_q;
        redirect_o.pc    = pc_q;
    end

endmodule

//--- flush_controller.sv
// --------------------
// Flush controller
// Builds per-stage flush strobes and runs the data cache fence
// handshake that halts the core
// --------------------

`timescale 1ns/1ps

`include "flush_settings.svh"

module flush_controller (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  flush_pkg::flush_req_t req_i,
    input  logic                  halt_csr_i,
    input  logic                  dcache_flush_ack_i,
    output flush_pkg::flush_vec_t flush_o,
    output logic                  dcache_flush_o,
    output logic                  halt_o
);

    flush_pkg::fence_state_e state_d;
    flush_pkg::fence_state_e state_q;
    logic                    dcache_flush_d;
    logic                    dcache_flush_q;
    // Fence that needs a cache writeback
    logic                    fence_start;
    // Commit-side events that restart fetch behind the commit PC
    logic                    commit_flush;

    assign commit_flush = req_i.fence | req_i.fence_i | req_i.sfence | req_i.hfence_vvma
                        | req_i.hfence_gvma | req_i.csr_flush;

    assign fence_start = (`FLUSH_WB_DCACHE == 1) && (req_i.fence || req_i.fence_i);

    // --------------------
    // Flush vector
    // --------------------
    always_comb begin : flush_vec
        flush_o = '0;

        // Mispredict only drops the front end
        if (req_i.mispredict) begin
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
        end

        // Serializing commit events
        if (commit_flush) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
        end

        // Instruction cache only on fence.i
        flush_o.flush_icache = req_i.fence_i;
        flush_o.flush_dcache = fence_start;

        // sfence hits the VS-stage TLB when virtualized
        if (req_i.sfence) begin
            if (req_i.virt && (`FLUSH_HYP_EN == 1)) begin
                flush_o.flush_tlb_vvma = 1'b1;
            end else begin
                flush_o.flush_tlb = 1'b1;
            end
        end

        if (req_i.hfence_vvma) begin
            flush_o.flush_tlb_vvma = 1'b1;
        end

        if (req_i.hfence_gvma) begin
            flush_o.flush_tlb_gvma = 1'b1;
        end

        // Trap entry and return take their own PC, not the commit PC
        if (req_i.exception || req_i.eret) begin
            flush_o.set_pc_commit  = 1'b0;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            // Stale predictions could fetch across the privilege change
            flush_o.flush_bp       = 1'b1;
        end
    end

    // --------------------
    // Fence handshake FSM
    // --------------------
    always_comb begin : fence_fsm
        state_d        = state_q;
        dcache_flush_d = 1'b0;
        unique case (state_q)
            flush_pkg::FENCE_IDLE: begin
                if (fence_start) begin
                    state_d        = flush_pkg::FENCE_WAIT_ACK;
                    dcache_flush_d = 1'b1;
                end
            end
            flush_pkg::FENCE_WAIT_ACK: begin
                // Hold the request until the cache answers
                if (dcache_flush_ack_i) begin
                    state_d = flush_pkg::FENCE_IDLE;
                end else begin
                    dcache_flush_d = 1'b1;
                end
            end
            default: state_d = flush_pkg::FENCE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= flush_pkg::FENCE_IDLE;
            dcache_flush_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            dcache_flush_q <= dcache_flush_d;
        end
    end

    assign dcache_flush_o = dcache_flush_q;

    // Core stalls for WFI or while the cache writes back
    assign halt_o = halt_csr_i || (state_q == flush_pkg::FENCE_WAIT_ACK);

endmodule

//--- commit_event_decoder.sv
// --------------------
// Commit event decoder
// Turns commit and branch strobes into a registered flush request
// --------------------

`timescale 1ns/1ps

`include "flush_settings.svh"

module commit_event_decoder (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  flush_pkg::commit_event_t   commit_i,
    input  flush_pkg::branch_resolve_t branch_i,
    output flush_pkg::flush_req_t      req_o
);

    flush_pkg::flush_req_t req_d;
    flush_pkg::flush_req_t req_q;

    // --------------------
    // Opcode decode
    // --------------------
    always_comb begin : decode
        req_d = '0;

        // Intent bits only for a valid commit
        if (commit_i.valid) begin
            unique case (commit_i.op)
                flush_pkg::OP_FENCE:       req_d.fence     = 1'b1;
                flush_pkg::OP_FENCE_I:     req_d.fence_i   = 1'b1;
                flush_pkg::OP_SFENCE_VMA:  req_d.sfence    = 1'b1;
                // Hypervisor fences vanish without the extension
                flush_pkg::OP_HFENCE_VVMA: req_d.hfence_vvma = (`FLUSH_HYP_EN == 1);
                flush_pkg::OP_HFENCE_GVMA: req_d.hfence_gvma = (`FLUSH_HYP_EN == 1);
                flush_pkg::OP_CSR_FLUSH:   req_d.csr_flush = 1'b1;
                flush_pkg::OP_EXCEPTION:   req_d.exception = 1'b1;
                flush_pkg::OP_ERET:        req_d.eret      = 1'b1;
                default:                   req_d.fence     = 1'b0;
            endcase
            req_d.virt = commit_i.virt;
        end

        // Branch side is independent of the commit strobe
        req_d.mispredict = branch_i.valid && branch_i.mispredict;

        // --------------------
        // Next-PC candidates
        // --------------------
        // Sequential PC after the committing instruction
        req_d.commit_pc = commit_i.pc + `FLUSH_XLEN'd4;

        // Trap vector on exception, epc otherwise
        if (commit_i.op == flush_pkg::OP_EXCEPTION) begin
            req_d.trap_target = `FLUSH_TRAP_VECTOR;
        end else begin
            req_d.trap_target = commit_i.target;
        end

        req_d.branch_target = branch_i.target;
    end

    // Request register, one cycle after the strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= '0;
        end else begin
            req_q <= req_d;
        end
    end

    assign req_o = req_q;

endmodule

//--- flush_pkg.sv
// --------------------
// Flush control types
// Opcodes, FSM states and the structs passed between the flush stages
// --------------------

`include "flush_settings.svh"

package flush_pkg;

    // Commit opcodes that can disturb the pipeline
    typedef enum logic [3:0] {
        OP_NONE        = 4'd0,
        OP_FENCE       = 4'd1,
        OP_FENCE_I     = 4'd2,
        OP_SFENCE_VMA  = 4'd3,
        OP_HFENCE_VVMA = 4'd4,
        OP_HFENCE_GVMA = 4'd5,
        OP_CSR_FLUSH   = 4'd6,
        OP_EXCEPTION   = 4'd7,
        OP_ERET        = 4'd8
    } commit_op_e;

    // Data cache fence handshake
    typedef enum logic {
        FENCE_IDLE     = 1'b0,
        FENCE_WAIT_ACK = 1'b1
    } fence_state_e;

    // Commit stage strobe
    typedef struct packed {
        logic                   valid;
        commit_op_e             op;
        // Hart runs in virtualized mode
        logic                   virt;
        logic [`FLUSH_XLEN-1:0] pc;
        // Epc for eret
        logic [`FLUSH_XLEN-1:0] target;
    } commit_event_t;

    // Resolved branch from execute
    typedef struct packed {
        logic                   valid;
        logic                   mispredict;
        logic [`FLUSH_XLEN-1:0] target;
    } branch_resolve_t;

    // Registered request, one intent bit per cause
    typedef struct packed {
        logic                   mispredict;
        logic                   fence;
        logic                   fence_i;
        logic                   sfence;
        logic                   hfence_vvma;
        logic                   hfence_gvma;
        logic                   csr_flush;
        logic                   exception;
        logic                   eret;
        logic                   virt;
        // Next-PC candidates
        logic [`FLUSH_XLEN-1:0] commit_pc;
        logic [`FLUSH_XLEN-1:0] trap_target;
        logic [`FLUSH_XLEN-1:0] branch_target;
    } flush_req_t;

    // Per-stage flush strobes
    typedef struct packed {
        logic set_pc_commit;
        logic flush_if;
        logic flush_unissued;
        logic flush_id;
        logic flush_ex;
        logic flush_bp;
        logic flush_icache;
        logic flush_dcache;
        logic flush_tlb;
        logic flush_tlb_vvma;
        logic flush_tlb_gvma;
    } flush_vec_t;

    // Fetch redirect
    typedef struct packed {
        logic                   valid;
        logic [`FLUSH_XLEN-1:0] pc;
    } redirect_t;

endpackage

//--- flush_settings.svh
// --------------------
// Flush control settings
// Widths and feature switches shared by the flush and redirect logic
// --------------------

`ifndef FLUSH_SETTINGS_SVH
`define FLUSH_SETTINGS_SVH

// PC and target width
`define FLUSH_XLEN 32

// Data cache write policy
// 1 means write-back, so fences need a cache flush handshake
`define FLUSH_WB_DCACHE 1

// Hypervisor extension present
// Enables hfence opcodes and the VS-stage TLB flush on sfence
`define FLUSH_HYP_EN 1

// Exception target taken on any trap
`define FLUSH_TRAP_VECTOR 32'h8000_0040

`endif
